/* tile_video.f */
logic/vid_pkg.sv
logic/vid_timer.sv
logic/vid_mmr.sv
logic/tile_layer.sv
logic/vid_colmix.sv
logic/tile_video.sv
tests/tb_clock.sv
tests/tile_video_assert.sv
tests/tb_tile_video.sv

/* run.sh */
#!/bin/sh
# Build and run the tile_video testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_tile_video -f tile_video.f || exit 1
out=$(./obj_dir/Vtb_tile_video)
echo "$out"
echo "$out" | grep -q "Everything OK" && echo "Simulation passed" || {
    echo "Simulation did not pass"
    exit 1
}

/* tests/tb_tile_video.sv */
`timescale 1ns/10ps

module tb_tile_video;

    localparam int H_ACTIVE   = 64;
    localparam int H_TOTAL    = 96;
    localparam int V_ACTIVE   = 32;
    localparam int V_TOTAL    = 40;
    localparam int HS_START   = 72;
    localparam int VS_START   = 34;
    localparam int FRAME      = H_TOTAL * V_TOTAL;  // Pixel enables per frame
    localparam int WAIT_LIMIT = 4 * FRAME;          // In clk cycles, two frames
    localparam int UNIT_MAP   = 0;
    localparam int UNIT_PAL   = 1;
    localparam int UNIT_MMR   = 2;

    logic                           clk;
    logic                           rst_n;
    logic                           pxl_cen;
    logic                           map_cs;
    logic                           pal_cs;
    logic                           mmr_cs;
    logic [10:0]                    cpu_addr;
    logic [15:0]                    cpu_dout;
    logic [ 1:0]                    dsn;
    logic [15:0]                    map_dout;
    logic [15:0]                    pal_dout;
    logic [15:0]                    mmr_dout;
    logic                           gfx_cs;
    logic [vid_pkg::GFX_ADDR_W-1:0] gfx_addr;
    logic                           gfx_ok;
    logic [31:0]                    gfx_data;
    logic                           hs;
    logic                           vs;
    logic                           lhbl;
    logic                           lvbl;
    logic                           vint;
    logic [ 4:0]                    red;
    logic [ 4:0]                    green;
    logic [ 4:0]                    blue;

    // Reference copies of what the CPU wrote
    logic [15:0] map_m [0:1023];
    logic [15:0] pal_m [0:255];
    logic [15:0] reg_m [0:1];
    integer      seed;
    int          cen_cnt;    // Pixel enables since reset
    bit          check_pix;  // RGB of active pixels compared when set

    tb_clock #(.PERIOD_NS(20)) tb_clock_i (.clk(clk));

    tile_video #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .HS_START ( HS_START ),
        .VS_START ( VS_START )
    ) tile_video_i (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .map_cs   ( map_cs   ),
        .pal_cs   ( pal_cs   ),
        .mmr_cs   ( mmr_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .dsn      ( dsn      ),
        .map_dout ( map_dout ),
        .pal_dout ( pal_dout ),
        .mmr_dout ( mmr_dout ),
        .gfx_cs   ( gfx_cs   ),
        .gfx_addr ( gfx_addr ),
        .gfx_ok   ( gfx_ok   ),
        .gfx_data ( gfx_data ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .vint     ( vint     ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

    // Graphics ROM contents, every address bit shows up in the word
    function automatic logic [31:0] rom_word(input logic [vid_pkg::GFX_ADDR_W-1:0] addr);
        return {addr, addr ^ 12'ha5c, addr[7:0] + 8'h3b};
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] data,
                                                input logic [1:0]  be_n);
        logic [15:0] res;
        res = old;
        if (!be_n[1]) begin
            res[15:8] = data[15:8];
        end
        if (!be_n[0]) begin
            res[7:0] = data[7:0];
        end
        return res;
    endfunction

    // Expected colour of the active pixel at x, y
    function automatic logic [15:0] pixel_colour(input int x, input int y);
        int          row;
        logic [15:0] entry;
        logic [31:0] word;
        logic [3:0]  nib;
        logic [7:0]  idx;
        row   = (y + int'(reg_m[0][7:0])) % 256;
        entry = map_m[10'((row / 8) % 32 * 32 + x / 8)];
        word  = rom_word(12'(int'(entry[8:0]) * 8 + row % 8));
        nib   = 4'(word >> (28 - 4 * (x % 8)));  // Leftmost pixel in the top nibble
        idx   = reg_m[1][0] ? {entry[12:9], nib} : 8'd0;
        return pal_m[idx];
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected === actual) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (expected === actual) else begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Something failed");
        $fatal(1, "Stopped on timeout");
    endtask

    task automatic cpu_write(input int unit, input logic [10:0] addr,
                             input logic [15:0] data, input logic [1:0] be_n);
        @(posedge clk);
        #2;
        cpu_addr = addr;
        cpu_dout = data;
        dsn      = be_n;
        map_cs   = unit == UNIT_MAP;
        pal_cs   = unit == UNIT_PAL;
        mmr_cs   = unit == UNIT_MMR;
        @(posedge clk);
        #2;
        map_cs = 1'b0;
        pal_cs = 1'b0;
        mmr_cs = 1'b0;
        if (unit == UNIT_MAP) begin
            map_m[addr[9:0]] = merge_bytes(map_m[addr[9:0]], data, be_n);
            check_value("map readback", map_m[addr[9:0]], map_dout);
        end else if (unit == UNIT_PAL) begin
            pal_m[addr[7:0]] = merge_bytes(pal_m[addr[7:0]], data, be_n);
            check_value("palette readback", pal_m[addr[7:0]], pal_dout);
        end else begin
            reg_m[addr[1]] = merge_bytes(reg_m[addr[1]], data, be_n);
            check_value("register readback", reg_m[addr[1]], mmr_dout);
        end
    endtask

    // Returns on the clk where vint is seen high
    task automatic wait_vint;
        int n;
        n = 0;
        @(negedge clk);
        while (!vint && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!vint) begin
            report_timeout("vint");
        end
    endtask

    // Timer outputs follow the count at once, RGB and blanking two enables later
    task automatic compare_video(input bit cen);
        int          p;
        int          x;
        int          y;
        logic [15:0] col;
        if (cen) begin
            cen_cnt++;
        end
        p = (cen_cnt + FRAME - 1) % FRAME;  // Reset leaves the timer on the last pixel
        x = p % H_TOTAL;
        y = p / H_TOTAL;
        check_bit("hs", x >= HS_START && x <= HS_START + 7, hs);
        check_bit("vs", y >= VS_START && y <= VS_START + 1, vs);
        check_bit("vint", cen && x == 0 && y == V_ACTIVE, vint);
        if (cen_cnt < 3) begin
            check_bit("lhbl after reset", 1'b0, lhbl);
            check_bit("lvbl after reset", 1'b0, lvbl);
            check_value("rgb after reset", 16'd0, {1'b0, red, green, blue});
        end else begin
            p = (cen_cnt - 3) % FRAME;
            x = p % H_TOTAL;
            y = p / H_TOTAL;
            check_bit("lhbl", x < H_ACTIVE, lhbl);
            check_bit("lvbl", y < V_ACTIVE, lvbl);
            if (x < H_ACTIVE && y < V_ACTIVE) begin
                if (check_pix) begin
                    col = pixel_colour(x, y);
                    check_value($sformatf("pixel x=%0d y=%0d", x, y), {1'b0, col[14:0]},
                                {1'b0, red, green, blue});
                end
            end else begin
                check_value($sformatf("blank x=%0d y=%0d", x, y), 16'd0,
                            {1'b0, red, green, blue});
            end
        end
    endtask

    always @(posedge clk) begin
        #2;
        pxl_cen = !pxl_cen;  // High on every second clk
    end

    initial begin : monitor
        bit cen;
        forever begin
            @(posedge clk);
            cen = pxl_cen && rst_n;
            @(negedge clk);
            compare_video(cen);
        end
    end

    initial begin : rom_model
        int n;
        int lat;
        forever begin
            n = 0;
            @(negedge clk);
            while (!gfx_cs && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!gfx_cs) begin
                report_timeout("a graphics ROM request");
            end
            lat = 1 + ($random(seed) & 3);
            repeat (2 * lat) @(posedge clk);  // Two clk per pixel enable
            #2;
            gfx_data = rom_word(gfx_addr);
            gfx_ok   = 1'b1;
            @(posedge clk);
            #2;
            gfx_ok = 1'b0;
        end
    end

    initial begin : main
        seed      = 32'h8c224563;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        map_cs    = 1'b0;
        pal_cs    = 1'b0;
        mmr_cs    = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        dsn       = 2'b11;
        gfx_ok    = 1'b0;
        gfx_data  = '0;
        check_pix = 1'b0;
        cen_cnt   = 0;
        reg_m[0]  = '0;
        reg_m[1]  = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Fill both RAMs, then random byte-lane writes anywhere
        for (int i = 0; i < 1024; i++) begin
            cpu_write(UNIT_MAP, 11'(i), 16'($random(seed)), 2'b00);
        end
        for (int i = 0; i < 256; i++) begin
            cpu_write(UNIT_PAL, 11'(i), 16'($random(seed)), 2'b00);
        end
        for (int i = 0; i < 96; i++) begin
            cpu_write(i % 3, 11'($random(seed)), 16'($random(seed)), 2'($random(seed)));
        end

        // Layer on with a random scroll, written in vertical blanking
        wait_vint();
        cpu_write(UNIT_MMR, 11'h000, 16'($random(seed)), 2'b00);
        cpu_write(UNIT_MMR, 11'h002, 16'h0001, 2'b00);
        check_pix = 1'b1;
        wait_vint();
        wait_vint();

        // New scroll value for the next frame
        cpu_write(UNIT_MMR, 11'h000, {8'($random(seed)), reg_m[0][7:0] ^ 8'h5a}, 2'b00);
        wait_vint();

        // Layer off shows palette entry 0
        cpu_write(UNIT_MMR, 11'h002, 16'h0000, 2'b00);
        wait_vint();

        $display("Everything OK");
        $finish;
    end

endmodule

/* tests/tile_video_assert.sv */
`timescale 1ns/10ps

module tile_video_assert (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           pxl_cen,
    input logic                           gfx_cs,
    input logic [vid_pkg::GFX_ADDR_W-1:0] gfx_addr,
    input logic                           gfx_ok,
    input logic                           vint
);

    logic [3:0] wait_cnt;  // Pixel enables spent waiting on the ROM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!gfx_cs || gfx_ok) begin
            wait_cnt <= '0;
        end else if (pxl_cen) begin
            wait_cnt <= wait_cnt + 4'd1;
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        gfx_cs && !gfx_ok |=> gfx_cs && $stable(gfx_addr))
        else $error("gfx_cs dropped or gfx_addr moved before gfx_ok");

    rom_latency: assert property (@(posedge clk) disable iff (!rst_n) wait_cnt <= 4'd6)
        else $error("graphics ROM took more than 6 pixel enables");

    vint_pulse: assert property (@(posedge clk) disable iff (!rst_n) vint |=> !vint)
        else $error("vint high for more than one clk");

endmodule

bind tile_video tile_video_assert tile_video_assert_i (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .pxl_cen  ( pxl_cen  ),
    .gfx_cs   ( gfx_cs   ),
    .gfx_addr ( gfx_addr ),
    .gfx_ok   ( gfx_ok   ),
    .vint     ( vint     )
);

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

/* logic/tile_video.sv */
`timescale 1ns/10ps

module tile_video #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL  = 96,
    parameter int V_ACTIVE = 32,
    parameter int V_TOTAL  = 40,
    parameter int HS_START = 72,
    parameter int VS_START = 34
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    // CPU side
    input  logic                          map_cs,
    input  logic                          pal_cs,
    input  logic                          mmr_cs,
    input  logic [10:0]                   cpu_addr,
    input  logic [15:0]                   cpu_dout,
    input  logic [ 1:0]                   dsn,
    output logic [15:0]                   map_dout,
    output logic [15:0]                   pal_dout,
    output logic [15:0]                   mmr_dout,
    // Graphics ROM
    output logic                          gfx_cs,
    output logic [vid_pkg::GFX_ADDR_W-1:0] gfx_addr,
    input  logic                          gfx_ok,
    input  logic [31:0]                   gfx_data,
    // Video out
    output logic                          hs,
    output logic                          vs,
    output logic                          lhbl,
    output logic                          lvbl,
    output logic                          vint,
    output logic [ 4:0]                   red,
    output logic [ 4:0]                   green,
    output logic [ 4:0]                   blue
);

    logic [8:0]                   hdump;
    logic [8:0]                   vdump;
    logic                         pre_lhbl;
    logic                         pre_lvbl;
    logic [7:0]                   vscroll;
    logic                         layer_en;
    logic [vid_pkg::PAL_IDX_W-1:0] pxl_idx;

    vid_timer #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .HS_START ( HS_START ),
        .VS_START ( VS_START )
    ) u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .pre_lhbl ( pre_lhbl ),
        .pre_lvbl ( pre_lvbl ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .vint     ( vint     )
    );

    vid_mmr u_mmr (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .mmr_cs   ( mmr_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .dsn      ( dsn      ),
        .mmr_dout ( mmr_dout ),
        .vscroll  ( vscroll  ),
        .layer_en ( layer_en )
    );

    tile_layer #(.H_TOTAL(H_TOTAL)) u_layer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .map_cs   ( map_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .dsn      ( dsn      ),
        .map_dout ( map_dout ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .vscroll  ( vscroll  ),
        .layer_en ( layer_en ),
        .gfx_cs   ( gfx_cs   ),
        .gfx_addr ( gfx_addr ),
        .gfx_ok   ( gfx_ok   ),
        .gfx_data ( gfx_data ),
        .pxl_idx  ( pxl_idx  )
    );

    vid_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pal_cs   ( pal_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .dsn      ( dsn      ),
        .pal_dout ( pal_dout ),
        .pre_lhbl ( pre_lhbl ),
        .pre_lvbl ( pre_lvbl ),
        .pxl_idx  ( pxl_idx  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

/* logic/vid_colmix.sv */
`timescale 1ns/10ps

module vid_colmix (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pxl_cen,
    input  logic                         pal_cs,
    input  logic [10:0]                  cpu_addr,
    input  logic [15:0]                  cpu_dout,
    input  logic [ 1:0]                  dsn,
    output logic [15:0]                  pal_dout,
    input  logic                         pre_lhbl,
    input  logic                         pre_lvbl,
    input  logic [vid_pkg::PAL_IDX_W-1:0] pxl_idx,
    output logic                         lhbl,
    output logic                         lvbl,
    output logic [ 4:0]                  red,
    output logic [ 4:0]                  green,
    output logic [ 4:0]                  blue
);

    localparam int PAL_SIZE = 2 ** vid_pkg::PAL_IDX_W;

    logic [15:0] pal_ram [0:PAL_SIZE-1];  // xRRRRRGGGGGBBBBB
    logic [15:0] col;
    logic        lhbl_d;
    logic        lvbl_d;

    always_ff @(posedge clk) begin
        if (pal_cs) begin
            if (!dsn[1]) begin
                pal_ram[cpu_addr[vid_pkg::PAL_IDX_W-1:0]][15:8] <= cpu_dout[15:8];
            end
            if (!dsn[0]) begin
                pal_ram[cpu_addr[vid_pkg::PAL_IDX_W-1:0]][7:0] <= cpu_dout[7:0];
            end
        end
    end

    assign pal_dout = pal_ram[cpu_addr[vid_pkg::PAL_IDX_W-1:0]];
    assign col      = pal_ram[pxl_idx];

    // Blanking goes through two stages, colour through one after the layer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_d <= 1'b0;
            lvbl_d <= 1'b0;
            lhbl   <= 1'b0;
            lvbl   <= 1'b0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else if (pxl_cen) begin
            lhbl_d <= pre_lhbl;
            lvbl_d <= pre_lvbl;
            lhbl   <= lhbl_d;
            lvbl   <= lvbl_d;
            if (lhbl_d && lvbl_d) begin
                red   <= col[14:10];
                green <= col[9:5];
                blue  <= col[4:0];
            end else begin
                red   <= '0;  // Black in blanking
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

/* logic/tile_layer.sv */
`timescale 1ns/10ps

module tile_layer #(
    parameter int H_TOTAL = 96
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic                          map_cs,
    input  logic [10:0]                   cpu_addr,
    input  logic [15:0]                   cpu_dout,
    input  logic [ 1:0]                   dsn,
    output logic [15:0]                   map_dout,
    input  logic [ 8:0]                   hdump,
    input  logic [ 8:0]                   vdump,
    input  logic [ 7:0]                   vscroll,
    input  logic                          layer_en,
    output logic                          gfx_cs,
    output logic [vid_pkg::GFX_ADDR_W-1:0] gfx_addr,
    input  logic                          gfx_ok,
    input  logic [31:0]                   gfx_data,
    output logic [vid_pkg::PAL_IDX_W-1:0]  pxl_idx
);

    logic [15:0] map_ram [0:1023];  // 32x32 entries

    vid_pkg::fetch_state_e st;
    logic                  first_grp;
    logic                  next_grp;
    logic                  load;
    logic [4:0]            grp;
    logic [7:0]            fetch_y;
    logic [7:0]            fetch_rowf;
    logic [9:0]            map_rd_addr;
    logic [2:0]            fetch_row;
    logic [12:0]           map_q;
    logic [31:0]           gfx_buf;   // Next group, waiting for its boundary
    logic [3:0]            pal_buf;
    logic [31:0]           shift;
    logic [3:0]            pal_cur;
    logic [8:0]            vend;      // Last line of the frame
    logic [8:0]            v_d;
    logic                  vend_set;

    always_ff @(posedge clk) begin
        if (map_cs) begin
            if (!dsn[1]) begin
                map_ram[cpu_addr[9:0]][15:8] <= cpu_dout[15:8];
            end
            if (!dsn[0]) begin
                map_ram[cpu_addr[9:0]][7:0] <= cpu_dout[7:0];
            end
        end
    end

    assign map_dout = map_ram[cpu_addr[9:0]];

    // The first group of a line is fetched on the previous line, so the
    // layer needs to know which line wraps to 0. The timer leaves reset on
    // its last line and the value is refreshed at every frame wrap.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vend     <= '0;
            v_d      <= '0;
            vend_set <= 1'b0;
        end else begin
            v_d <= vdump;
            if (!vend_set) begin
                vend     <= vdump;
                vend_set <= 1'b1;
            end else if (vdump == 9'd0 && v_d != 9'd0) begin
                vend <= v_d;
            end
        end
    end

    assign first_grp  = hdump == 9'(H_TOTAL - 8);
    assign next_grp   = hdump[2:0] == 3'd0 && hdump < 9'(H_TOTAL - 16);
    assign load       = hdump[2:0] == 3'd0;  // Group boundary
    assign grp        = first_grp ? 5'd0 : hdump[7:3] + 5'd1;
    assign fetch_y    = first_grp ? ((vdump == vend) ? 8'd0 : vdump[7:0] + 8'd1) : vdump[7:0];
    assign fetch_rowf = fetch_y + vscroll;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st          <= vid_pkg::FETCH_IDLE;
            gfx_cs      <= 1'b0;
            gfx_addr    <= '0;
            map_rd_addr <= '0;
            fetch_row   <= '0;
        end else begin
            case (st)
                vid_pkg::FETCH_IDLE: begin
                    if (pxl_cen && (first_grp || next_grp)) begin
                        map_rd_addr <= {fetch_rowf[7:3], grp};
                        fetch_row   <= fetch_rowf[2:0];
                        st          <= vid_pkg::FETCH_MAP;
                    end
                end
                vid_pkg::FETCH_MAP: st <= vid_pkg::FETCH_GFX;  // map_q loads here
                vid_pkg::FETCH_GFX: begin
                    gfx_addr <= {map_q[8:0], fetch_row};
                    gfx_cs   <= 1'b1;
                    st       <= vid_pkg::FETCH_WAIT;
                end
                vid_pkg::FETCH_WAIT: begin
                    if (gfx_ok) begin
                        gfx_cs <= 1'b0;
                        st     <= vid_pkg::FETCH_IDLE;
                    end
                end
                default: st <= vid_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == vid_pkg::FETCH_MAP) begin
            map_q <= map_ram[map_rd_addr][12:0];
        end
        if (st == vid_pkg::FETCH_WAIT && gfx_ok) begin
            gfx_buf <= gfx_data;
            pal_buf <= map_q[12:9];
        end
        if (pxl_cen) begin
            if (load) begin
                shift   <= {gfx_buf[27:0], 4'd0};
                pal_cur <= pal_buf;
            end else begin
                shift <= {shift[27:0], 4'd0};  // Leftmost pixel on top
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_idx <= '0;
        end else if (pxl_cen) begin
            if (!layer_en) begin
                pxl_idx <= '0;
            end else if (load) begin
                pxl_idx <= {pal_buf, gfx_buf[31:28]};
            end else begin
                pxl_idx <= {pal_cur, shift[31:28]};
            end
        end
    end

endmodule

/* logic/vid_mmr.sv */
`timescale 1ns/10ps

module vid_mmr (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mmr_cs,
    input  logic [10:0] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [ 1:0] dsn,
    output logic [15:0] mmr_dout,
    output logic [ 7:0] vscroll,
    output logic        layer_en
);

    logic [15:0]       regs [0:1];
    vid_pkg::mmr_reg_e sel;

    assign sel = vid_pkg::mmr_reg_e'(cpu_addr[1]);

    // Byte lanes are active low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs[0] <= '0;
            regs[1] <= '0;
        end else if (mmr_cs) begin
            if (!dsn[1]) begin
                regs[sel][15:8] <= cpu_dout[15:8];
            end
            if (!dsn[0]) begin
                regs[sel][7:0] <= cpu_dout[7:0];
            end
        end
    end

    assign mmr_dout = regs[sel];  // Full word readback

    assign vscroll  = regs[vid_pkg::REG_VSCROLL][7:0];
    assign layer_en = regs[vid_pkg::REG_CTRL][0];

endmodule

/* logic/vid_timer.sv */
`timescale 1ns/10ps

module vid_timer #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL  = 96,
    parameter int V_ACTIVE = 32,
    parameter int V_TOTAL  = 40,
    parameter int HS_START = 72,
    parameter int VS_START = 34
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       pre_lhbl,
    output logic       pre_lvbl,
    output logic       hs,
    output logic       vs,
    output logic       vint
);

    logic       h_wrap;
    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    always_comb begin
        h_wrap = hdump == 9'(H_TOTAL - 1);
        h_nxt  = h_wrap ? 9'd0 : hdump + 9'd1;
        v_nxt  = vdump;
        if (h_wrap) begin
            v_nxt = (vdump == 9'(V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    // Levels are decoded from the next count, so they line up with hdump/vdump
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump    <= 9'(H_TOTAL - 1);  // Last pixel of the frame
            vdump    <= 9'(V_TOTAL - 1);
            pre_lhbl <= 1'b0;
            pre_lvbl <= 1'b0;
            hs       <= 1'b0;
            vs       <= 1'b0;
            vint     <= 1'b0;
        end else begin
            // Single clk pulse as the first blank line starts
            vint <= pxl_cen && h_wrap && v_nxt == 9'(V_ACTIVE);
            if (pxl_cen) begin
                hdump    <= h_nxt;
                vdump    <= v_nxt;
                pre_lhbl <= h_nxt < 9'(H_ACTIVE);
                pre_lvbl <= v_nxt < 9'(V_ACTIVE);
                hs       <= h_nxt >= 9'(HS_START) && h_nxt <= 9'(HS_START + 7);
                vs       <= v_nxt >= 9'(VS_START) && v_nxt <= 9'(VS_START + 1);
            end
        end
    end

endmodule

/* logic/vid_pkg.sv */
package vid_pkg;

    // Palette index is a 4-bit palette followed by a 4-bit pixel nibble
    localparam int PAL_IDX_W = 8;

    // Graphics ROM word address, tile code then row in tile
    localparam int GFX_ADDR_W = 12;

    // Register select, taken from cpu_addr[1]
    typedef enum logic {
        REG_VSCROLL = 1'b0,  // Vertical scroll in bits 7:0
        REG_CTRL    = 1'b1   // Bit 0 enables the tile layer
    } mmr_reg_e;

    // Tile layer fetch sequence
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_MAP  = 2'd1,  // Map RAM read
        FETCH_GFX  = 2'd2,  // ROM request goes out
        FETCH_WAIT = 2'd3   // Hold request until gfx_ok
    } fetch_state_e;

endpackage
